// ==== compile.f ====
src/vec_cfg_pkg.sv
src/vec_isa_pkg.sv
src/vec_sequencer.sv
src/vec_beat_counter.sv
src/vec_config_regs.sv
src/vec_regfile.sv
src/vec_operand_stage.sv
src/vec_alu.sv
src/vec_unit_top.sv
tb/vec_unit_properties.sv
tb/vec_unit_tb.sv

// ==== Makefile ====
TOP := vec_unit_tb

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f compile.f
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	test $$status -eq 0 && ! grep -q "Checks failed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// ==== tb/vec_unit_tb.sv ====
`timescale 1ns/1ns

module vec_unit_tb;
    import vec_cfg_pkg::*;
    import vec_isa_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    localparam int SETTLE_NS    = 1;

    // One row of the stimulus table
    // For vset rows vd holds rd and vs1 holds rs1 or the uimm
    typedef struct packed {
        instr_kind_e kind;
        vec_op_e     op;
        op_cat_e     cat;
        logic [4:0]  vd;
        logic [4:0]  vs2;
        logic [4:0]  vs1;
        vsew_e       sew;
        vlmul_e      lmul;
        scalar_t     scalar;
        scalar_t     exp_res;
        logic        exp_wr_en;
    } row_t;

    logic        clk;
    logic        reset_n;
    vec_instr_u  instr_i;
    instr_kind_e instr_kind_i;
    vec_op_e     vec_op_i;
    scalar_t     scalar_i;
    logic        hold_o;
    scalar_t     res_scalar_o;
    logic        wr_en_scalar_o;

    row_t rows[$];
    logic table_ready;

    vec_unit_top i_vec_unit_top (
        .clk            (clk),
        .reset_n        (reset_n),
        .instr_i        (instr_i),
        .instr_kind_i   (instr_kind_i),
        .vec_op_i       (vec_op_i),
        .scalar_i       (scalar_i),
        .hold_o         (hold_o),
        .res_scalar_o   (res_scalar_o),
        .wr_en_scalar_o (wr_en_scalar_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Table construction
    ////////////////////////////////////////////////////////////////////////////

    // funct6 codes of the RVV integer operations
    function automatic logic [5:0] funct6_of(vec_op_e op);
        logic [5:0] f;
        case (op)
            VSUB:    f = 6'b000010;
            VMINU:   f = 6'b000100;
            VMIN:    f = 6'b000101;
            VMAXU:   f = 6'b000110;
            VMAX:    f = 6'b000111;
            VAND:    f = 6'b001001;
            VOR:     f = 6'b001010;
            VXOR:    f = 6'b001011;
            VSLL:    f = 6'b100101;
            VSRL:    f = 6'b101000;
            default: f = 6'b000000;
        endcase
        return f;
    endfunction

    task automatic add_vset(instr_kind_e kind, int rd, int rs1, vsew_e sew, vlmul_e lmul,
                            scalar_t avl, int exp_vl);
        row_t r;
        r.kind      = kind;
        r.op        = VNOP;
        r.cat       = OPIVV;
        r.vd        = 5'(rd);
        r.vs2       = 5'(0);
        r.vs1       = 5'(rs1);
        r.sew       = sew;
        r.lmul      = lmul;
        r.scalar    = avl;
        r.exp_res   = scalar_t'(exp_vl);
        r.exp_wr_en = 1'b1;
        rows.push_back(r);
    endtask

    task automatic add_vop(vec_op_e op, op_cat_e cat, int vd, int vs2, int vs1,
                           scalar_t scalar, scalar_t exp_res);
        row_t r;
        r.kind      = VECTOR;
        r.op        = op;
        r.cat       = cat;
        r.vd        = 5'(vd);
        r.vs2       = 5'(vs2);
        r.vs1       = 5'(vs1);
        r.sew       = EW8;
        r.lmul      = LMUL_1;
        r.scalar    = scalar;
        r.exp_res   = exp_res;
        r.exp_wr_en = 1'b0;
        rows.push_back(r);
    endtask

    task automatic build_table();
        // VLMAX for each width and group size
        add_vset(VSETVLI, 1, 0, EW8,  LMUL_1, 0, 8);
        add_vset(VSETVLI, 1, 0, EW8,  LMUL_2, 0, 16);
        add_vset(VSETVLI, 1, 0, EW8,  LMUL_4, 0, 32);
        add_vset(VSETVLI, 1, 0, EW8,  LMUL_8, 0, 64);
        add_vset(VSETVLI, 1, 0, EW16, LMUL_1, 0, 4);
        add_vset(VSETVLI, 1, 0, EW16, LMUL_2, 0, 8);
        add_vset(VSETVLI, 1, 0, EW16, LMUL_4, 0, 16);
        add_vset(VSETVLI, 1, 0, EW16, LMUL_8, 0, 32);
        add_vset(VSETVLI, 1, 0, EW32, LMUL_1, 0, 2);
        add_vset(VSETVLI, 1, 0, EW32, LMUL_2, 0, 4);
        add_vset(VSETVLI, 1, 0, EW32, LMUL_4, 0, 8);
        add_vset(VSETVLI, 1, 0, EW32, LMUL_8, 0, 16);
        // AVL above and below VLMAX
        add_vset(VSETVLI, 1, 5, EW8, LMUL_1, 100, 8);
        add_vset(VSETVLI, 1, 5, EW8, LMUL_1, 3, 3);
        // Immediate AVL, then a vl-preserving vsetvli
        add_vset(VSETIVLI, 1, 5, EW8, LMUL_1, 0, 5);
        add_vset(VSETVLI, 0, 0, EW8, LMUL_1, 0, 5);
        // Fill v1 to v4 from v0
        add_vset(VSETVLI, 1, 0, EW8, LMUL_1, 0, 8);
        add_vop(VADD, OPIVX, 1, 0, 0, 32'h0000005a, 32'h5a5a5a5a);
        add_vset(VSETVLI, 1, 0, EW16, LMUL_1, 0, 4);
        add_vop(VADD, OPIVX, 2, 0, 0, 32'h1234abcd, 32'habcdabcd);
        add_vset(VSETVLI, 1, 0, EW32, LMUL_1, 0, 2);
        add_vop(VADD, OPIVX, 3, 0, 0, 32'h80000001, 32'h80000001);
        add_vop(VADD, OPIVI, 4, 0, 5'b11101, 0, 32'hfffffffd);
        add_vop(VMIN,  OPIVV, 17, 3, 1, 0, 32'h80000001);
        add_vop(VMINU, OPIVV, 18, 3, 1, 0, 32'h5a5a5a5a);
        // Byte lanes of v1 against v2
        add_vset(VSETVLI, 1, 0, EW8, LMUL_1, 0, 8);
        add_vop(VSUB,  OPIVV, 5, 1, 2, 0, 32'haf8daf8d);
        add_vop(VAND,  OPIVV, 6, 1, 2, 0, 32'h0a480a48);
        add_vop(VOR,   OPIVV, 7, 1, 2, 0, 32'hfbdffbdf);
        add_vop(VXOR,  OPIVV, 8, 1, 2, 0, 32'hf197f197);
        add_vop(VSLL,  OPIVI, 9, 1, 3, 0, 32'hd0d0d0d0);
        add_vop(VSRL,  OPIVX, 10, 2, 0, 4, 32'h0a0c0a0c);
        add_vop(VMIN,  OPIVV, 13, 1, 2, 0, 32'habcdabcd);
        add_vop(VMINU, OPIVV, 14, 1, 2, 0, 32'h5a5a5a5a);
        add_vop(VMAX,  OPIVV, 15, 1, 2, 0, 32'h5a5a5a5a);
        add_vop(VMAXU, OPIVV, 16, 1, 2, 0, 32'habcdabcd);
        // Halfword lanes
        add_vset(VSETVLI, 1, 0, EW16, LMUL_1, 0, 4);
        add_vop(VSUB, OPIVV, 12, 1, 2, 0, 32'hae8dae8d);
        add_vop(VSRL, OPIVI, 11, 2, 5'b10100, 0, 32'h0abc0abc);
        // Two-register group, last beat is v21
        add_vset(VSETVLI, 1, 0, EW8, LMUL_2, 0, 16);
        add_vop(VADD, OPIVV, 20, 1, 1, 0, 32'h569a569a);
        // Short vl leaves the tail of v22 at zero
        add_vset(VSETVLI, 1, 5, EW8, LMUL_1, 3, 3);
        add_vop(VADD, OPIVX, 22, 0, 0, 32'h00000077, 32'h77777777);
        add_vset(VSETVLI, 1, 0, EW8, LMUL_1, 0, 8);
        add_vop(VADD, OPIVV, 23, 22, 0, 0, 32'h00777777);
        // v0 ignores writes
        add_vop(VADD, OPIVX, 0, 0, 0, 32'h00000011, 32'h11111111);
        add_vop(VADD, OPIVV, 24, 0, 0, 0, 32'h00000000);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Drive, wait and compare
    ////////////////////////////////////////////////////////////////////////////

    task automatic drive_row(row_t r);
        vec_instr_u w;
        w = '0;
        if (r.kind == VECTOR) begin
            w.arith.funct6 = funct6_of(r.op);
            w.arith.vm     = 1'b1;
            w.arith.vs2    = r.vs2;
            w.arith.vs1    = r.vs1;
            w.arith.funct3 = r.cat;
            w.arith.vd     = r.vd;
        end else begin
            // vsetivli sets both bit 31 and bit 30
            w.vset.top    = (r.kind == VSETIVLI);
            w.vset.zimm   = {(r.kind == VSETIVLI), 4'b0000, r.sew, r.lmul};
            w.vset.rs1    = r.vs1;
            w.vset.funct3 = 3'b111;
            w.vset.rd     = r.vd;
        end
        w.arith.opcode = 7'b1010111;
        instr_i        = w;
        instr_kind_i   = r.kind;
        vec_op_i       = r.op;
        scalar_i       = r.scalar;
    endtask

    // Returns in the cycle where hold_o is low and the row retires
    task automatic wait_retire();
        #(SETTLE_NS);
        while (hold_o) begin
            @(negedge clk);
            #(SETTLE_NS);
        end
    endtask

    task automatic check_scalar(scalar_t actual, scalar_t expected, string what);
        if (actual !== expected) begin
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, actual,
                     expected);
            $display("Checks failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic check_flag(logic actual, logic expected, string what);
        if (actual !== expected) begin
            $display("mismatch at %0t ns: %s is %b, expected %b", $time, what, actual,
                     expected);
            $display("Checks failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    initial begin : watchdog
        time limit;
        wait (table_ready);
        limit = (rows.size() * (LMUL_MAX + 3) + RESET_CYCLES + 4) * CLK_PERIOD;
        #(limit);
        $display("Timeout: the vector unit did not retire every table row in %0t ns", limit);
        $display("Checks failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        clk          = 1'b0;
        reset_n      = 1'b0;
        instr_i      = '0;
        instr_kind_i = NONE;
        vec_op_i     = VNOP;
        scalar_i     = '0;
        table_ready  = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        reset_n = 1'b1;
        foreach (rows[i]) begin
            @(negedge clk);
            drive_row(rows[i]);
            wait_retire();
            check_scalar(res_scalar_o, rows[i].exp_res, $sformatf("row %0d res_scalar_o", i));
            check_flag(wr_en_scalar_o, rows[i].exp_wr_en,
                       $sformatf("row %0d wr_en_scalar_o", i));
        end
        if (i_vec_unit_top.i_vec_unit_properties.fail_count == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Handshake assertions failed during the run");
            $display("Checks failed");
            $fatal(1, "assertion failures");
        end
    end

endmodule

// ==== tb/vec_unit_properties.sv ====
`timescale 1ns/1ns

module vec_unit_properties (
    input logic clk,
    input logic reset_n,
    input logic hold_i,
    input logic wr_en_scalar_i
);
    import vec_cfg_pkg::*;

    // Read by the testbench when the table is done
    int unsigned fail_count = 0;

    // Consecutive cycles with the core stalled
    int unsigned hold_run;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            hold_run <= 0;
        end else if (hold_i) begin
            hold_run <= hold_run + 1;
        end else begin
            hold_run <= 0;
        end
    end

    // A full LMUL 8 group plus the two drain cycles at most
    a_hold_released: assert property (
        @(posedge clk) disable iff (!reset_n) hold_run <= LMUL_MAX + 2
    ) else begin
        fail_count++;
        $error("hold_o stayed high longer than a full register group and drain");
    end

    a_no_scalar_under_hold: assert property (
        @(posedge clk) disable iff (!reset_n) !(wr_en_scalar_i && hold_i)
    ) else begin
        fail_count++;
        $error("wr_en_scalar_o was high while hold_o was high");
    end

    a_idle_after_reset: assert property (
        @(posedge clk) $rose(reset_n) |-> !hold_i
    ) else begin
        fail_count++;
        $error("hold_o was high in the first cycle after reset");
    end

endmodule

bind vec_unit_top vec_unit_properties i_vec_unit_properties (
    .clk            (clk),
    .reset_n        (reset_n),
    .hold_i         (hold_o),
    .wr_en_scalar_i (wr_en_scalar_o)
);

// ==== src/vec_unit_top.sv ====
`timescale 1ns/1ns

module vec_unit_top (
    input  logic                      clk,
    input  logic                      reset_n,
    input  vec_isa_pkg::vec_instr_u   instr_i,
    input  vec_isa_pkg::instr_kind_e  instr_kind_i,
    input  vec_isa_pkg::vec_op_e      vec_op_i,
    input  vec_cfg_pkg::scalar_t      scalar_i,
    output logic                      hold_o,
    output vec_cfg_pkg::scalar_t      res_scalar_o,
    output logic                      wr_en_scalar_o
);
    import vec_cfg_pkg::*;
    import vec_isa_pkg::*;

    // Sequencing
    logic       issue;
    logic       count_clr;
    logic       last_beat;
    logic       drain_done;
    vreg_addr_t beat;

    // Configuration
    vsew_e      vsew;
    vlmul_e     vlmul;
    vl_t        vl;

    // Register file read side
    vreg_addr_t rd_addr_a;
    vreg_addr_t rd_addr_b;
    vreg_t      rd_data_a;
    vreg_t      rd_data_b;

    // Operand stage to ALU
    vreg_t      op_a;
    vreg_t      op_b;
    vreg_addr_t opnd_wr_addr;
    byte_en_t   opnd_byte_en;
    logic       opnd_valid;

    // ALU to register file write port
    vreg_t      alu_result;
    vreg_addr_t wr_addr;
    byte_en_t   wr_byte_en;
    logic       wr_valid;
    scalar_t    alu_word;

    vec_sequencer i_vec_sequencer (
        .clk          (clk),
        .reset_n      (reset_n),
        .instr_kind_i (instr_kind_i),
        .last_beat_i  (last_beat),
        .drain_done_i (drain_done),
        .hold_o       (hold_o),
        .issue_o      (issue),
        .count_clr_o  (count_clr)
    );

    vec_beat_counter i_vec_beat_counter (
        .clk          (clk),
        .reset_n      (reset_n),
        .clear_i      (count_clr),
        .vlmul_i      (vlmul),
        .count_o      (beat),
        .last_beat_o  (last_beat),
        .drain_done_o (drain_done)
    );

    vec_config_regs i_vec_config_regs (
        .clk            (clk),
        .reset_n        (reset_n),
        .instr_i        (instr_i),
        .instr_kind_i   (instr_kind_i),
        .scalar_i       (scalar_i),
        .alu_word_i     (alu_word),
        .vsew_o         (vsew),
        .vlmul_o        (vlmul),
        .vl_o           (vl),
        .res_scalar_o   (res_scalar_o),
        .wr_en_scalar_o (wr_en_scalar_o)
    );

    vec_regfile i_vec_regfile (
        .clk          (clk),
        .reset_n      (reset_n),
        .rd_addr_a_i  (rd_addr_a),
        .rd_addr_b_i  (rd_addr_b),
        .wr_addr_i    (wr_addr),
        .wr_data_i    (alu_result),
        .wr_byte_en_i (wr_byte_en),
        .wr_valid_i   (wr_valid),
        .rd_data_a_o  (rd_data_a),
        .rd_data_b_o  (rd_data_b)
    );

    vec_operand_stage i_vec_operand_stage (
        .clk         (clk),
        .reset_n     (reset_n),
        .issue_i     (issue),
        .beat_i      (beat),
        .instr_i     (instr_i),
        .vsew_i      (vsew),
        .vl_i        (vl),
        .scalar_i    (scalar_i),
        .rd_data_a_i (rd_data_a),
        .rd_data_b_i (rd_data_b),
        .rd_addr_a_o (rd_addr_a),
        .rd_addr_b_o (rd_addr_b),
        .op_a_o      (op_a),
        .op_b_o      (op_b),
        .wr_addr_o   (opnd_wr_addr),
        .byte_en_o   (opnd_byte_en),
        .valid_o     (opnd_valid)
    );

    vec_alu i_vec_alu (
        .clk           (clk),
        .reset_n       (reset_n),
        .vec_op_i      (vec_op_i),
        .vsew_i        (vsew),
        .op_a_i        (op_a),
        .op_b_i        (op_b),
        .wr_addr_i     (opnd_wr_addr),
        .byte_en_i     (opnd_byte_en),
        .valid_i       (opnd_valid),
        .result_o      (alu_result),
        .wr_addr_o     (wr_addr),
        .wr_byte_en_o  (wr_byte_en),
        .wr_valid_o    (wr_valid),
        .result_word_o (alu_word)
    );

endmodule

// ==== src/vec_alu.sv ====
`timescale 1ns/1ns

module vec_alu (
    input  logic                    clk,
    input  logic                    reset_n,
    input  vec_isa_pkg::vec_op_e    vec_op_i,
    input  vec_isa_pkg::vsew_e      vsew_i,
    input  vec_cfg_pkg::vreg_t      op_a_i,
    input  vec_cfg_pkg::vreg_t      op_b_i,
    input  vec_cfg_pkg::vreg_addr_t wr_addr_i,
    input  vec_cfg_pkg::byte_en_t   byte_en_i,
    input  logic                    valid_i,
    output vec_cfg_pkg::vreg_t      result_o,
    output vec_cfg_pkg::vreg_addr_t wr_addr_o,
    output vec_cfg_pkg::byte_en_t   wr_byte_en_o,
    output logic                    wr_valid_o,
    output vec_cfg_pkg::scalar_t    result_word_o
);
    import vec_cfg_pkg::*;
    import vec_isa_pkg::*;

    vreg_t alu_out;

    ////////////////////////////////////////////////////////////////////////////
    // One lane
    ////////////////////////////////////////////////////////////////////////////

    // Lane moved to the top of a word, so carries and sign bits land where
    // a native w-bit operation would put them
    function automatic scalar_t lane_calc(vec_op_e op, scalar_t a, scalar_t b,
                                          int unsigned w);
        scalar_t     a_al;
        scalar_t     b_al;
        scalar_t     r;
        int unsigned sh;
        a_al = a << (32 - w);
        b_al = b << (32 - w);
        sh   = b & (w - 1);
        case (op)
            VADD:    r = a_al + b_al;
            VSUB:    r = a_al - b_al;
            VAND:    r = a_al & b_al;
            VOR:     r = a_al | b_al;
            VXOR:    r = a_al ^ b_al;
            VSLL:    r = a_al << sh;
            VSRL:    r = a_al >> sh;
            VMINU:   r = (a_al < b_al) ? a_al : b_al;
            VMAXU:   r = (a_al > b_al) ? a_al : b_al;
            VMIN:    r = ($signed(a_al) < $signed(b_al)) ? a_al : b_al;
            VMAX:    r = ($signed(a_al) > $signed(b_al)) ? a_al : b_al;
            default: r = '0;
        endcase
        return r >> (32 - w);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // All lanes at the current SEW
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        int unsigned w;
        scalar_t     lane_r;
        case (vsew_i)
            EW8:     w = 8;
            EW16:    w = 16;
            default: w = 32;
        endcase
        alu_out = '0;
        for (int j = 0; j < VLEN / 32; j++) begin
            for (int k = 0; k < 4; k++) begin
                if (k * w < 32) begin
                    lane_r = lane_calc(vec_op_i, op_a_i[32*j +: 32] >> (k * w),
                                       op_b_i[32*j +: 32] >> (k * w), w);
                    alu_out[32*j +: 32] = alu_out[32*j +: 32] | (lane_r << (k * w));
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Result register and write port
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_valid_o <= 1'b0;
        end else begin
            wr_valid_o <= valid_i;
        end
    end

    // Holds the last beat so the core can read its low word
    always_ff @(posedge clk) begin
        if (valid_i) begin
            result_o     <= alu_out;
            wr_addr_o    <= wr_addr_i;
            wr_byte_en_o <= byte_en_i;
        end
    end

    assign result_word_o = result_o[31:0];

endmodule

// ==== src/vec_operand_stage.sv ====
`timescale 1ns/1ns

module vec_operand_stage (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    issue_i,
    input  vec_cfg_pkg::vreg_addr_t beat_i,
    input  vec_isa_pkg::vec_instr_u instr_i,
    input  vec_isa_pkg::vsew_e      vsew_i,
    input  vec_cfg_pkg::vl_t        vl_i,
    input  vec_cfg_pkg::scalar_t    scalar_i,
    input  vec_cfg_pkg::vreg_t      rd_data_a_i,
    input  vec_cfg_pkg::vreg_t      rd_data_b_i,
    output vec_cfg_pkg::vreg_addr_t rd_addr_a_o,
    output vec_cfg_pkg::vreg_addr_t rd_addr_b_o,
    output vec_cfg_pkg::vreg_t      op_a_o,
    output vec_cfg_pkg::vreg_t      op_b_o,
    output vec_cfg_pkg::vreg_addr_t wr_addr_o,
    output vec_cfg_pkg::byte_en_t   byte_en_o,
    output logic                    valid_o
);
    import vec_cfg_pkg::*;
    import vec_isa_pkg::*;

    vreg_t    op_b_d;
    byte_en_t byte_en_d;
    scalar_t  imm_ext;
    logic     is_shift;

    // Copy one element into every lane at the given width
    function automatic vreg_t replicate(scalar_t word, vsew_e sew);
        vreg_t rep;
        case (sew)
            EW8:     rep = {(VLENB){word[7:0]}};
            EW16:    rep = {(VLENB / 2){word[15:0]}};
            default: rep = {(VLENB / 4){word}};
        endcase
        return rep;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Register addresses and operand selection
    ////////////////////////////////////////////////////////////////////////////

    assign rd_addr_a_o = instr_i.arith.vs2 + beat_i;
    assign rd_addr_b_o = instr_i.arith.vs1 + beat_i;

    assign is_shift = instr_i.arith.funct6 inside {FUNCT6_VSLL, FUNCT6_VSRL};
    assign imm_ext  = is_shift ? {27'b0, instr_i.arith.vs1}
                               : {{27{instr_i.arith.vs1[4]}}, instr_i.arith.vs1};

    always_comb begin
        case (op_cat_e'(instr_i.arith.funct3))
            OPIVX:   op_b_d = replicate(scalar_i, vsew_i);
            OPIVI:   op_b_d = replicate(imm_ext, vsew_i);
            default: op_b_d = rd_data_b_i;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Tail byte enables
    ////////////////////////////////////////////////////////////////////////////

    // Byte offset across the whole group, scaled down to an element index
    always_comb begin
        int unsigned elem_idx;
        for (int i = 0; i < VLENB; i++) begin
            elem_idx     = (32'(beat_i) * VLENB + i) >> vsew_i;
            byte_en_d[i] = (elem_idx < 32'(vl_i));
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= issue_i;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_i) begin
            op_a_o    <= rd_data_a_i;
            op_b_o    <= op_b_d;
            wr_addr_o <= instr_i.arith.vd + beat_i;
            byte_en_o <= byte_en_d;
        end
    end

endmodule

// ==== src/vec_regfile.sv ====
`timescale 1ns/1ns

module vec_regfile (
    input  logic                    clk,
    input  logic                    reset_n,
    input  vec_cfg_pkg::vreg_addr_t rd_addr_a_i,
    input  vec_cfg_pkg::vreg_addr_t rd_addr_b_i,
    input  vec_cfg_pkg::vreg_addr_t wr_addr_i,
    input  vec_cfg_pkg::vreg_t      wr_data_i,
    input  vec_cfg_pkg::byte_en_t   wr_byte_en_i,
    input  logic                    wr_valid_i,
    output vec_cfg_pkg::vreg_t      rd_data_a_o,
    output vec_cfg_pkg::vreg_t      rd_data_b_o
);
    import vec_cfg_pkg::*;

    vreg_t vregs [NUM_VREGS];

    assign rd_data_a_o = vregs[rd_addr_a_i];
    assign rd_data_b_o = vregs[rd_addr_b_i];

    // v0 is the mask register and stays untouched
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int r = 0; r < NUM_VREGS; r++) begin
                vregs[r] <= '0;
            end
        end else if (wr_valid_i && wr_addr_i != '0) begin
            for (int b = 0; b < VLENB; b++) begin
                if (wr_byte_en_i[b]) begin
                    vregs[wr_addr_i][8*b +: 8] <= wr_data_i[8*b +: 8];
                end
            end
        end
    end

endmodule

// ==== src/vec_config_regs.sv ====
`timescale 1ns/1ns

module vec_config_regs (
    input  logic                      clk,
    input  logic                      reset_n,
    input  vec_isa_pkg::vec_instr_u   instr_i,
    input  vec_isa_pkg::instr_kind_e  instr_kind_i,
    input  vec_cfg_pkg::scalar_t      scalar_i,
    input  vec_cfg_pkg::scalar_t      alu_word_i,
    output vec_isa_pkg::vsew_e        vsew_o,
    output vec_isa_pkg::vlmul_e       vlmul_o,
    output vec_cfg_pkg::vl_t          vl_o,
    output vec_cfg_pkg::scalar_t      res_scalar_o,
    output logic                      wr_en_scalar_o
);
    import vec_cfg_pkg::*;
    import vec_isa_pkg::*;

    logic    is_vset;
    vsew_e   vsew_next;
    vlmul_e  vlmul_next;
    vl_t     vlmax;
    vl_t     vl_next;
    scalar_t avl;

    ////////////////////////////////////////////////////////////////////////////
    // New vtype and vector length
    ////////////////////////////////////////////////////////////////////////////

    assign is_vset    = instr_kind_i inside {VSETVLI, VSETIVLI};
    assign vsew_next  = vsew_e'(instr_i.vset.zimm[5:3]);
    assign vlmul_next = vlmul_e'(instr_i.vset.zimm[2:0]);

    // Elements per register, times the group size
    assign vlmax = (vl_t'(VLENB) >> vsew_next) << vlmul_next;

    // vsetivli carries AVL in the rs1 field
    assign avl = (instr_kind_i == VSETIVLI) ? scalar_t'(instr_i.vset.rs1) : scalar_i;

    always_comb begin
        if (instr_kind_i == VSETVLI && instr_i.vset.rs1 == '0) begin
            vl_next = (instr_i.vset.rd != '0) ? vlmax : vl_o;
        end else if (avl > scalar_t'(vlmax)) begin
            vl_next = vlmax;
        end else begin
            vl_next = vl_t'(avl);
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            vsew_o  <= EW8;
            vlmul_o <= LMUL_1;
            vl_o    <= '0;
        end else if (is_vset) begin
            vsew_o  <= vsew_next;
            vlmul_o <= vlmul_next;
            vl_o    <= vl_next;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Scalar result to the core
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        wr_en_scalar_o = is_vset;
        if (is_vset) begin
            res_scalar_o = scalar_t'(vl_next);
        end else if (instr_kind_i == VECTOR) begin
            res_scalar_o = alu_word_i;
        end else begin
            res_scalar_o = '0;
        end
    end

endmodule

// ==== src/vec_beat_counter.sv ====
`timescale 1ns/1ns

module vec_beat_counter (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    clear_i,
    input  vec_isa_pkg::vlmul_e     vlmul_i,
    output vec_cfg_pkg::vreg_addr_t count_o,
    output logic                    last_beat_o,
    output logic                    drain_done_o
);
    import vec_cfg_pkg::*;

    vreg_addr_t group_last;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            count_o <= '0;
        end else if (clear_i) begin
            count_o <= '0;
        end else begin
            count_o <= count_o + 1'b1;
        end
    end

    // Group size minus one
    assign group_last = vreg_addr_t'((1 << vlmul_i) - 1);

    assign last_beat_o  = (count_o == group_last);
    assign drain_done_o = (count_o == vreg_addr_t'(1));

endmodule

// ==== src/vec_sequencer.sv ====
`timescale 1ns/1ns

module vec_sequencer (
    input  logic                      clk,
    input  logic                      reset_n,
    input  vec_isa_pkg::instr_kind_e  instr_kind_i,
    input  logic                      last_beat_i,
    input  logic                      drain_done_i,
    output logic                      hold_o,
    output logic                      issue_o,
    output logic                      count_clr_o
);
    import vec_isa_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        EXEC,
        DRAIN
    } state_e;

    state_e state;
    state_e next_state;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:    if (instr_kind_i == VECTOR) next_state = EXEC;
            EXEC:    if (last_beat_i) next_state = DRAIN;
            DRAIN:   if (drain_done_i) next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    // Core stalls until the FSM is about to return to IDLE
    assign hold_o      = (next_state != IDLE);
    assign issue_o     = (state == EXEC);
    assign count_clr_o = (next_state != state);

endmodule

// ==== src/vec_isa_pkg.sv ====
package vec_isa_pkg;

    typedef enum logic [2:0] {
        EW8  = 3'b000,
        EW16 = 3'b001,
        EW32 = 3'b010
    } vsew_e;

    typedef enum logic [2:0] {
        LMUL_1 = 3'b000,
        LMUL_2 = 3'b001,
        LMUL_4 = 3'b010,
        LMUL_8 = 3'b011
    } vlmul_e;

    // Operand source as encoded in funct3
    typedef enum logic [2:0] {
        OPIVV = 3'b000,
        OPIVI = 3'b011,
        OPIVX = 3'b100
    } op_cat_e;

    typedef enum logic [1:0] {
        NONE,
        VECTOR,
        VSETVLI,
        VSETIVLI
    } instr_kind_e;

    typedef enum logic [3:0] {
        VNOP,
        VADD,
        VSUB,
        VAND,
        VOR,
        VXOR,
        VSLL,
        VSRL,
        VMINU,
        VMAXU,
        VMIN,
        VMAX
    } vec_op_e;

    // Shifts take a zero-extended immediate
    localparam logic [5:0] FUNCT6_VSLL = 6'b100101;
    localparam logic [5:0] FUNCT6_VSRL = 6'b101000;

    typedef struct packed {
        logic [5:0] funct6;
        logic       vm;
        logic [4:0] vs2;
        logic [4:0] vs1;
        logic [2:0] funct3;
        logic [4:0] vd;
        logic [6:0] opcode;
    } varith_fmt_t;

    typedef struct packed {
        logic        top;
        logic [10:0] zimm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } vsetvl_fmt_t;

    typedef union packed {
        varith_fmt_t arith;
        vsetvl_fmt_t vset;
    } vec_instr_u;

endpackage

// ==== src/vec_cfg_pkg.sv ====
package vec_cfg_pkg;

    // Register geometry
    localparam int VLEN        = 64;
    localparam int VLENB       = VLEN / 8;
    localparam int NUM_VREGS   = 32;
    localparam int VREG_ADDR_W = 5;
    localparam int LMUL_MAX    = 8;

    // Enough bits to hold VLENB * LMUL_MAX itself
    localparam int VL_W = $clog2(VLENB * LMUL_MAX) + 1;

    typedef logic [VLEN-1:0]        vreg_t;
    typedef logic [VLENB-1:0]       byte_en_t;
    typedef logic [VREG_ADDR_W-1:0] vreg_addr_t;
    typedef logic [31:0]            scalar_t;
    typedef logic [VL_W-1:0]        vl_t;

endpackage
